// ==== source/cactus_sprites.mem ====
// 60-bit cactus bitmap rows, leftmost character is bit 59, rightmost is bit 0
// rows 0..57 are shape 0, rows 58..115 shape 1, rows 116..173 shape 2
000000000000000000000000111111111111000000000000000000000000
000000000000000000000000111111111111000000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000011110011111111111111110011110000000000000000
000000000000000011110011111111111111110011110000000000000000
000000000000000011110011111111111111110011110000000000000000
000000000000000011110011111111111111110011110000000000000000
000000000000000011110011111111111111110011110000000000000000
000000000000000011110011111111111111110011110000000000000000
000000000000000011110011111111111111110011110000000000000000
000000000000000011110011111111111111110011110000000000000000
000000000000000011110011111111111111110011110000000000000000
000000000000000011110011111111111111110011110000000000000000
000000000000000011111111111111111111111111110000000000000000
000000000000000011111111111111111111111111110000000000000000
000000000000000011111111111111111111111111110000000000000000
000000000000000011111111111111111111111111110000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000011111111111111110000000000000000000000
000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000
001111110000000000000000000000000000000000111111000000000000
001111110000000000000000000000000000000000111111000000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111111000000000000000000000000000001111111111100000000
011111111111000000000000000000000000000001111111111100000000
011111111111000000000000000000000000000001111111111100000000
011111111111000000000000000000000000000001111111111100000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
011111111000000000000000000000000000000001111111100000000000
000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000
000000000000000000000000000000000000000000000000000000000000
000000000000001111000000000000000000000000000000000000000000
000000000000001111000000000000000000000000000000000000000000
000000000000011111100000000000000000000000000000000000000000
000000000000011111100000000000000000000000000000000000000000
000000000000011111100000000000000000000000000000000000000000
000000000000011111100000000000000000000000000000000000000000
000000000000011111100000000000000000000000000000000000000000
000000000000011111100000000000000000000000000000000000000000
000000000000011111100000000000000000000000000000000000000000
000000000000011111100000000000000000000000000000000000000000
000000000000011111100000000000000000000000000000000000000000
000000000000011111100000000000000000000000000000000000000000
000000000000011111100000000000000000000000000000000000000000
000000000000011111100000000000000000000000000000000000000000
000000000000011111100000000000001111000000000000000000000000
000000000000011111100000000000001111000000000000000000000000
000000000000011111100000000000011111100000000000000001111000
000000000000011111100000000000011111100000000000000001111000
000000000000011111100000000000011111100000000000000001111000
000000000000011111100000000000011111100000000000000001111000
000000000000011111100000000000011111100000000000000001111000
000000000000011111100000000000011111100000000000000001111000
000000000000011111100000000000011111100000000000000001111000
000000000000011111100000000000011111100000000000000001111000
000000000000011111100000000000011111100000000000000001111000
000000000000011111100000000000011111100000000000000001111000
000000000000011111100000000000011111100000000000000001111000
000000000000011111100000000000011111100000000000000001111000
000000000000011111100000000000011111100000000000000001111000
000000000000011111100000000000011111100000000000000001111000
000000000000011111100000000000011111100000000000000001111110
000000000000011111100000000000011111100000000000000001111110
000000000000011111100000000000011111100000000000000001111110
000000000000011111100000000000011111100000000000000001111110
000000000000011111100000000000011111100000000000000001111110
000000000000011111100000000000011111100000000000000001111110
000000000000011111100000000000011111100000000000000001111110
000000000000011111100000000000011111100000000000000001111110
000000000000011111100000000000011111100000000000000001111110
000000000000011111100000000000011111100000000000000001111110
000000000000011111100000000000011111100000000000000001111110
000000000000011111100000000000011111100000000000000001111110
000000000000011111100000000000011111100000000000000001111110
000000000000011111100000000000011111100000000000000001111110
000000000000011111100000000000011111100000000000000001111110
000000000000011111100000000000011111100000000000000001111110
000000000000011111100000000000011111100000000000000001111110
000000000000011111100000000000011111100000000000000001111110

// ==== filelist.f ====
+incdir+testbench
source/cactus_pkg.sv
source/obstacle_motion.sv
source/sprite_rom.sv
source/scan_renderer.sv
source/cactus_layer.sv
testbench/tb_cactus_layer.sv

// ==== Bender.yml ====
package:
  name: cactus_layer

sources:
  - files:
      - source/cactus_pkg.sv
      - source/obstacle_motion.sv
      - source/sprite_rom.sv
      - source/scan_renderer.sv
      - source/cactus_layer.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_cactus_layer.sv

// ==== testbench/tb_cactus_checks.svh ====
`ifndef TB_CACTUS_CHECKS_SVH
`define TB_CACTUS_CHECKS_SVH

sprite_row_t sprite_model [sprite_rows * shape_count];
logic [15:0] model_lfsr;
int          model_count;
int          model_wait;
obstacle_t   model_obs;

task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at the first failure");
endtask

task automatic compare_obstacle(input obstacle_t expected, input obstacle_t actual);
    if (expected !== actual) begin
        // fields are visible/shape/position
        $display("error %s: obstacle expected %0b/%0d/%0d actual %0b/%0d/%0d", test_name,
                 expected.visible, expected.shape, expected.position,
                 actual.visible, actual.shape, actual.position);
        abort_run();
    end
endtask

task automatic compare_px(input logic expected, input logic actual);
    if (expected !== actual) begin
        $display("error %s: px expected %b actual %b", test_name, expected, actual);
        abort_run();
    end
endtask

function automatic logic [15:0] lfsr_step(input logic [15:0] value);
    return {value[14:0], value[15] ^ value[13] ^ value[12] ^ value[10]};
endfunction

// one frame tick with the game running
task automatic model_frame(input speed_t spd);
    int next_pos;
    model_lfsr = lfsr_step(model_lfsr);
    if (!model_obs.visible) begin
        if (model_count >= model_wait) begin
            model_obs.visible  = 1'b1;
            model_obs.position = col_t'(spd);
            model_obs.shape    = shape_t'(model_lfsr[7:0] % shape_count);
            model_wait         = model_lfsr % wait_limit;
            model_count        = 0;
        end else begin
            model_count++;
        end
    end else begin
        next_pos = int'(model_obs.position) + int'(spd);
        if (next_pos >= track_length) begin
            model_obs.visible  = 1'b0;
            model_obs.position = '0;
        end else begin
            model_obs.position = col_t'(next_pos);
        end
    end
endtask

// window and bit rule on the bitmap copy
function automatic logic expected_px(input scan_t s, input obstacle_t o);
    int row;
    int sprite_col;
    row        = int'(s.row) - band_top;
    sprite_col = int'(s.col) + int'(o.position) - screen_width;
    if (!o.visible || row < 0 || row >= sprite_rows)
        return 1'b0;
    if (sprite_col < 0 || sprite_col >= sprite_cols)
        return 1'b0;
    return sprite_model[int'(o.shape) * sprite_rows + row][sprite_col];
endfunction

task automatic frames_until_visible(input logic want, input int limit);
    int frames;
    frames = 0;
    while (obstacle.visible !== want) begin
        if (frames == limit) begin
            $display("the cactus did not turn %s within %0d frames",
                     want ? "visible" : "hidden", limit);
            abort_run();
        end else begin
            game_frame();
            frames++;
        end
    end
endtask

task automatic frames_until_position(input col_t target, input int limit);
    int frames;
    frames = 0;
    while (obstacle.position < target) begin
        if (frames == limit) begin
            $display("the cactus did not scroll to position %0d within %0d frames",
                     target, limit);
            abort_run();
        end else begin
            game_frame();
            frames++;
        end
    end
endtask

`endif

// ==== testbench/tb_cactus_layer.sv ====
`default_nettype none

module tb_cactus_layer
    import cactus_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [15:0] seed_lfsr = 16'hace1;

    logic      RESET;
    logic      reset;
    logic      frame_tick;
    logic      game_status;
    logic      start;
    speed_t    speed;
    scan_t     scan;
    logic      px;
    obstacle_t obstacle;
    string     test_name;

    cactus_layer #(
        .lfsr_seed(seed_lfsr)
    ) dut0 (
        .RESET      (RESET),
        .reset      (reset),
        .frame_tick (frame_tick),
        .game_status(game_status),
        .start      (start),
        .speed      (speed),
        .scan       (scan),
        .px         (px),
        .obstacle   (obstacle)
    );

    `include "tb_cactus_checks.svh"

    initial begin
        RESET = 1'b0;
        forever #4 RESET = ~RESET;
    end

    task automatic step();
        @(posedge RESET);
        #1; // inputs move just after the edge
    endtask

    task automatic game_frame();
        frame_tick = 1'b1;
        step();
        frame_tick = 1'b0;
        if (game_status)
            model_frame(speed);
        compare_obstacle(model_obs, obstacle);
    endtask

    // px of a scan shows up two cycles after it is presented
    task automatic check_scan(input scan_t s);
        logic want;
        want = expected_px(s, model_obs);
        scan = s;
        step();
        step();
        compare_px(want, px);
    endtask

    function automatic scan_t random_scan();
        scan_t s;
        s.row = row_t'($urandom_range(479, 0));
        s.col = col_t'($urandom_range(screen_width - 1, 0));
        return s;
    endfunction

    // rows a little past the band, columns around the sprite's left edge
    function automatic scan_t window_scan();
        scan_t s;
        int    col;
        col = screen_width - int'(model_obs.position) - 8 + int'($urandom_range(75, 0));
        if (col < 0)
            col = 0;
        if (col >= screen_width)
            col = screen_width - 1;
        s.row = row_t'($urandom_range(band_top + sprite_rows + 7, band_top - 8));
        s.col = col_t'(col);
        return s;
    endfunction

    task automatic test_reset_hold();
        test_name = "reset_hold";
        compare_obstacle(obstacle_t'('0), obstacle);
        repeat (20) check_scan(random_scan());
        game_status = 1'b0;
        repeat (3) game_frame();
    endtask

    task automatic test_first_appearance();
        logic [15:0] first_value;
        obstacle_t   want;
        test_name   = "first_appearance";
        first_value = lfsr_step(seed_lfsr);
        want.visible  = 1'b1;
        want.shape    = shape_t'(first_value[7:0] % shape_count);
        want.position = col_t'(5);
        game_status = 1'b1;
        speed       = speed_t'(5);
        game_frame();
        compare_obstacle(want, obstacle);
    endtask

    task automatic test_scroll_exit();
        test_name = "scroll_exit";
        frames_until_visible(1'b0, track_length / 5 + 2);
        frames_until_visible(1'b1, wait_limit + 2); // model checks the exact frame
    endtask

    task automatic test_pixel_lookup();
        test_name = "pixel_lookup";
        frames_until_position(col_t'(320), 80);
        repeat (150) check_scan(window_scan());
        frames_until_position(col_t'(660), 80); // partly off the left edge
        repeat (150) check_scan(window_scan());
    endtask

    task automatic test_restart();
        scan_t s;
        int    issued;
        test_name   = "restart";
        game_status = 1'b0;
        start       = 1'b1;
        step();
        start = 1'b0;
        model_obs.visible  = 1'b0;
        model_obs.position = '0;
        compare_obstacle(model_obs, obstacle);
        issued = 0;
        for (int r = band_top; r < band_top + sprite_rows; r++) begin
            for (int c = 0; c < screen_width; c += 4) begin
                s.row = row_t'(r);
                s.col = col_t'(c);
                scan  = s;
                step();
                if (issued > 0) begin
                    compare_px(1'b0, px); // result of the previous scan
                end
                issued++;
            end
        end
        step();
        compare_px(1'b0, px);
    endtask

    initial begin
        void'($urandom(32'hc34d_8691));
        $readmemb("source/cactus_sprites.mem", sprite_model);
        reset       = 1'b1;
        frame_tick  = 1'b0;
        game_status = 1'b0;
        start       = 1'b0;
        speed       = '0;
        scan        = '0;
        test_name   = "setup";
        model_lfsr  = seed_lfsr;
        model_count = 0;
        model_wait  = 0;
        model_obs   = '0;
        repeat (5) @(posedge RESET);
        #1;
        reset = 1'b0;
        test_reset_hold();
        test_first_appearance();
        test_scroll_exit();
        test_pixel_lookup();
        test_restart();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/cactus_layer.sv ====
`default_nettype none

module cactus_layer
    import cactus_pkg::*;
#(
    parameter logic [15:0] lfsr_seed = 16'hace1
) (
    input  wire logic   RESET,
    input  wire logic   reset,
    input  wire logic   frame_tick,
    input  wire logic   game_status,
    input  wire logic   start,
    input  wire speed_t speed,
    input  wire scan_t  scan,
    output logic        px,
    output obstacle_t   obstacle
);

    rom_addr_t   rom_addr;
    sprite_row_t rom_data;

    obstacle_motion #(
        .lfsr_seed(lfsr_seed)
    ) motion0 (
        .RESET      (RESET),
        .reset      (reset),
        .frame_tick (frame_tick),
        .game_status(game_status),
        .start      (start),
        .speed      (speed),
        .obstacle   (obstacle)
    );

    sprite_rom rom0 (
        .RESET   (RESET),
        .rom_addr(rom_addr),
        .rom_data(rom_data)
    );

    // two-stage lookup, px follows scan by two cycles
    scan_renderer render0 (
        .RESET   (RESET),
        .reset   (reset),
        .scan    (scan),
        .obstacle(obstacle),
        .rom_addr(rom_addr),
        .rom_data(rom_data),
        .px      (px)
    );

endmodule

`default_nettype wire

// ==== source/scan_renderer.sv ====
`default_nettype none

module scan_renderer
    import cactus_pkg::*;
(
    input  wire logic        RESET,
    input  wire logic        reset,
    input  wire scan_t       scan,
    input  wire obstacle_t   obstacle,
    output rom_addr_t        rom_addr,
    input  wire sprite_row_t rom_data,
    output logic             px
);

    localparam row_t band_first = row_t'(band_top);
    localparam row_t band_end   = row_t'(band_top + sprite_rows);

    row_t       band_row;
    col_t       left_edge;
    col_t       right_edge;
    col_t       sprite_col;
    logic       in_band;
    logic       hit;
    logic       hit_q;
    logic [5:0] sprite_col_q;

    // stage 0: address the ROM and test the window
    assign band_row = scan.row - band_first;
    assign rom_addr = '{shape: obstacle.shape, row: band_row[5:0]};

    assign in_band    = (scan.row >= band_first) && (scan.row < band_end);
    assign left_edge  = (obstacle.position < col_t'(screen_width)) ?
                        col_t'(screen_width) - obstacle.position : '0;
    assign right_edge = col_t'(track_length) - obstacle.position;
    assign sprite_col = scan.col + obstacle.position - col_t'(screen_width);

    assign hit = in_band && obstacle.visible &&
                 (scan.col >= left_edge) && (scan.col < right_edge);

    always_ff @(posedge RESET) begin
        if (reset) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= hit;
        end
    end

    always_ff @(posedge RESET) begin
        sprite_col_q <= sprite_col[5:0]; // 0 .. 59 whenever hit
    end

    // stage 1: pick the bit, rom_data lines up with hit_q
    always_ff @(posedge RESET) begin
        if (reset) begin
            px <= 1'b0;
        end else begin
            px <= hit_q & rom_data[sprite_col_q];
        end
    end

    // nothing is drawn outside the sprite band, whatever the ROM returns
    no_px_outside_band: assert property (
        @(posedge RESET) disable iff (reset)
        !in_band |-> ##2 !px
    );

endmodule

`default_nettype wire

// ==== source/sprite_rom.sv ====
`default_nettype none

module sprite_rom
    import cactus_pkg::*;
(
    input  wire logic      RESET,
    input  wire rom_addr_t rom_addr,
    output sprite_row_t    rom_data
);

    localparam int depth = sprite_rows * shape_count;

    sprite_row_t mem [depth];
    logic [7:0]  index;

    initial begin
        $readmemb("source/cactus_sprites.mem", mem); // shape 0, then 1, then 2
    end

    // rows past the band give an index that is never used
    assign index = 8'(rom_addr.shape) * 8'(sprite_rows) + 8'(rom_addr.row);

    always_ff @(posedge RESET) begin
        rom_data <= mem[index];
    end

endmodule

`default_nettype wire

// ==== source/obstacle_motion.sv ====
`default_nettype none

module obstacle_motion
    import cactus_pkg::*;
#(
    parameter logic [15:0] lfsr_seed = 16'hace1
) (
    input  wire logic   RESET,
    input  wire logic   reset,
    input  wire logic   frame_tick,
    input  wire logic   game_status,
    input  wire logic   start,
    input  wire speed_t speed,
    output obstacle_t   obstacle
);

    logic [15:0] lfsr;
    logic [15:0] lfsr_next;
    logic [9:0]  wait_count;
    logic [9:0]  wait_time;
    logic [10:0] advance;   // one bit wider so the end of track is seen

    // fibonacci form, taps 16 14 13 11
    assign lfsr_next = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};

    assign advance = {1'b0, obstacle.position} + 11'(speed);

    always_ff @(posedge RESET) begin
        if (reset) begin
            lfsr       <= lfsr_seed;
            wait_count <= '0;
            wait_time  <= '0;
            obstacle   <= '0;
        end else if (game_status) begin
            if (frame_tick) begin
                lfsr <= lfsr_next; // only steps while the game runs
                if (!obstacle.visible) begin
                    wait_count <= wait_count + 10'd1;
                    if (wait_count >= wait_time) begin
                        // wait over, launch a new cactus at the right edge
                        obstacle.visible  <= 1'b1;
                        obstacle.position <= col_t'(speed);
                        obstacle.shape    <= shape_t'(lfsr_next[7:0] % shape_count);
                        wait_time         <= 10'(lfsr_next % wait_limit);
                        wait_count        <= '0;
                    end
                end else if (advance >= 11'(track_length)) begin
                    obstacle.visible  <= 1'b0; // scrolled out on the left
                    obstacle.position <= '0;
                end else begin
                    obstacle.position <= advance[9:0];
                end
            end
        end else if (start) begin
            obstacle.visible  <= 1'b0;
            obstacle.position <= '0;
        end
    end

    // the shape pick is mod 3, so code 3 would point past the ROM
    shape_in_range: assert property (
        @(posedge RESET) disable iff (reset)
        obstacle.shape != 2'd3
    );

    // the renderer window math relies on this bound
    position_in_track: assert property (
        @(posedge RESET) disable iff (reset)
        obstacle.position < col_t'(track_length)
    );

endmodule

`default_nettype wire

// ==== source/cactus_pkg.sv ====
`default_nettype none

package cactus_pkg;

    // screen and sprite geometry
    parameter int screen_width = 640;
    parameter int sprite_rows  = 58;
    parameter int sprite_cols  = 60;
    parameter int track_length = screen_width + sprite_cols; // cactus fully off the left edge
    parameter int band_top     = 344;                        // first row of the sprite band
    parameter int wait_limit   = 300;                        // wait times 0 .. 299 frames
    parameter int shape_count  = 3;

    typedef logic [9:0]             col_t;
    typedef logic [8:0]             row_t;
    typedef logic [1:0]             shape_t;
    typedef logic [3:0]             speed_t;   // pixels per frame
    typedef logic [sprite_cols-1:0] sprite_row_t;

    typedef struct packed {
        row_t row;
        col_t col;
    } scan_t;

    typedef struct packed {
        logic   visible;
        shape_t shape;
        col_t   position;  // distance scrolled in from the right edge
    } obstacle_t;

    // renderer to ROM request
    typedef struct packed {
        shape_t     shape;
        logic [5:0] row;
    } rom_addr_t;

endpackage

`default_nettype wire
